//--- csr_counter.sv
/*
 64-bit machine counter kept as two writable 32-bit halves.
 Counts on inc_i unless inhibited; a high-half write also takes the low carry.
*/
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_counter (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   inc_i,      // count event this cycle
    input  logic                   inhibit_i,  // from mcountinhibit
    input  logic                   wr_lo_i,
    input  logic                   wr_hi_i,
    input  logic [`CSR_XLEN-1:0]   wdata_i,
    output logic [2*`CSR_XLEN-1:0] count_o
);

    logic [`CSR_XLEN-1:0] lo_q;
    logic [`CSR_XLEN-1:0] hi_q;
    logic                 step;
    logic                 carry;

    assign step  = inc_i & ~inhibit_i;
    assign carry = step & (lo_q == '1);  // low half wraps this cycle

    always_ff @(posedge clk) begin
        if (rst_i) begin
            lo_q <= '0;
            hi_q <= '0;
        end else begin
            if (wr_lo_i) begin
                lo_q <= wdata_i;
            end else if (step) begin
                lo_q <= lo_q + 1'b1;
            end

            // carry still lands on a written high half
            if (wr_hi_i) begin
                hi_q <= wdata_i + {{(`CSR_XLEN-1){1'b0}}, carry};
            end else if (carry) begin
                hi_q <= hi_q + 1'b1;
            end
        end
    end

    assign count_o = {hi_q, lo_q};

endmodule

//--- csr_decode.sv
/*
 Address decoder for one CSR port.
 Raises the select bit of the addressed register; unknown addresses select nothing.
*/
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_decode (
    input  logic [`CSR_ADDR_W-1:0] addr_i,
    output csr_pkg::csr_sel_t      sel_o
);

    always_comb begin
        sel_o = '0;
        case (addr_i)
            `CSR_MTVEC:         sel_o.regs.mtvec         = 1'b1;
            `CSR_MEPC:          sel_o.regs.mepc          = 1'b1;
            `CSR_MCAUSE:        sel_o.regs.mcause        = 1'b1;
            `CSR_MSTATUS:       sel_o.regs.mstatus       = 1'b1;
            `CSR_MIE:           sel_o.regs.mie           = 1'b1;
            `CSR_MSCRATCH:      sel_o.regs.mscratch      = 1'b1;
            `CSR_MTVAL:         sel_o.regs.mtval         = 1'b1;
            `CSR_MCOUNTINHIBIT: sel_o.regs.mcountinhibit = 1'b1;

            // counters
            `CSR_MCYCLE:        sel_o.regs.mcycle        = 1'b1;
            `CSR_MCYCLEH:       sel_o.regs.mcycleh       = 1'b1;
            `CSR_MINSTRET:      sel_o.regs.minstret      = 1'b1;
            `CSR_MINSTRETH:     sel_o.regs.minstreth     = 1'b1;

            `CSR_MISA:          sel_o.misa               = 1'b1;  // read only
            default: begin
                // dropped or unknown csr, all zero
            end
        endcase
    end

endmodule

//--- csr_file.sv
/*
 Machine-mode CSR file, top level.
 ex and clint each get a write port and a combinational read port;
 mtvec, mepc, mstatus and mie are also presented to the clint on trap_o.
*/
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_file (
    input  logic                    clk,
    input  logic                    rst_i,

    // write ports
    input  csr_pkg::csr_wr_t        ex_wr_i,
    input  csr_pkg::csr_wr_t        clint_wr_i,

    // read addresses
    input  logic [`CSR_ADDR_W-1:0]  ex_raddr_i,
    input  logic [`CSR_ADDR_W-1:0]  clint_raddr_i,

    input  logic                    inst_valid_i,   // one pulse per retired instr

    output logic [`CSR_XLEN-1:0]    ex_rdata_o,
    output logic [`CSR_XLEN-1:0]    clint_rdata_o,
    output csr_pkg::csr_trap_view_t trap_o
);

    csr_pkg::csr_sel_t       ex_wsel;
    csr_pkg::csr_sel_t       clint_wsel;
    csr_pkg::csr_sel_t       ex_rsel;
    csr_pkg::csr_sel_t       clint_rsel;
    csr_pkg::csr_wen_t       wen;
    csr_pkg::csr_trap_view_t trap;
    csr_pkg::csr_view_t      view;

    logic [`CSR_XLEN-1:0]    mcause;
    logic [`CSR_XLEN-1:0]    mscratch;
    logic [`CSR_XLEN-1:0]    mtval;
    logic [`CSR_XLEN-1:0]    mcountinhibit;
    logic [2*`CSR_XLEN-1:0]  mcycle;
    logic [2*`CSR_XLEN-1:0]  minstret;
    logic [`CSR_XLEN-1:0]    cyc_wdata;
    logic [`CSR_XLEN-1:0]    ret_wdata;

    // address decode, two write and two read
    csr_decode u_dec_ex_wr    (.addr_i(ex_wr_i.addr),    .sel_o(ex_wsel));
    csr_decode u_dec_clint_wr (.addr_i(clint_wr_i.addr), .sel_o(clint_wsel));
    csr_decode u_dec_ex_rd    (.addr_i(ex_raddr_i),      .sel_o(ex_rsel));
    csr_decode u_dec_clint_rd (.addr_i(clint_raddr_i),   .sel_o(clint_rsel));

    csr_write_arb u_write_arb (
        .ex_wr_i    (ex_wr_i),
        .clint_wr_i (clint_wr_i),
        .ex_sel_i   (ex_wsel),
        .clint_sel_i(clint_wsel),
        .wen_o      (wen)
    );

    csr_trap_regs u_trap_regs (
        .clk            (clk),
        .rst_i          (rst_i),
        .wen_i          (wen),
        .trap_o         (trap),
        .mcause_o       (mcause),
        .mscratch_o     (mscratch),
        .mtval_o        (mtval),
        .mcountinhibit_o(mcountinhibit)
    );

    // each counter takes ex data if ex touches either half
    assign cyc_wdata = (wen.use_ex.mcycle | wen.use_ex.mcycleh) ? wen.ex_data
                                                                : wen.clint_data;
    assign ret_wdata = (wen.use_ex.minstret | wen.use_ex.minstreth) ? wen.ex_data
                                                                    : wen.clint_data;

    csr_counter u_mcycle (
        .clk      (clk),
        .rst_i    (rst_i),
        .inc_i    (1'b1),  // every cycle
        .inhibit_i(mcountinhibit[`CSR_INHIBIT_CY]),
        .wr_lo_i  (wen.en.mcycle),
        .wr_hi_i  (wen.en.mcycleh),
        .wdata_i  (cyc_wdata),
        .count_o  (mcycle)
    );

    csr_counter u_minstret (
        .clk      (clk),
        .rst_i    (rst_i),
        .inc_i    (inst_valid_i),
        .inhibit_i(mcountinhibit[`CSR_INHIBIT_IR]),
        .wr_lo_i  (wen.en.minstret),
        .wr_hi_i  (wen.en.minstreth),
        .wdata_i  (ret_wdata),
        .count_o  (minstret)
    );

    always_comb begin
        view.trap          = trap;
        view.mcause        = mcause;
        view.mscratch      = mscratch;
        view.mtval         = mtval;
        view.mcountinhibit = mcountinhibit;
        view.mcycle        = mcycle;
        view.minstret      = minstret;
    end

    csr_read_port u_read_ex (
        .raddr_sel_i(ex_rsel),
        .view_i     (view),
        .wr_i       (ex_wr_i),
        .raddr_i    (ex_raddr_i),
        .rdata_o    (ex_rdata_o)
    );

    csr_read_port u_read_clint (
        .raddr_sel_i(clint_rsel),
        .view_i     (view),
        .wr_i       (clint_wr_i),
        .raddr_i    (clint_raddr_i),
        .rdata_o    (clint_rdata_o)
    );

    assign trap_o = trap;

endmodule

//--- csr_file_asserts.sv
/*
 Concurrent checks for the CSR file, attached to csr_file with bind.
 Keeps a shadow of the clint trap view built from the two write ports.
*/
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_file_asserts (
    input logic                    clk,
    input logic                    rst_i,
    input csr_pkg::csr_wr_t        ex_wr_i,
    input csr_pkg::csr_wr_t        clint_wr_i,
    input logic [`CSR_ADDR_W-1:0]  ex_raddr_i,
    input logic [`CSR_ADDR_W-1:0]  clint_raddr_i,
    input logic [`CSR_XLEN-1:0]    ex_rdata_i,
    input logic [`CSR_XLEN-1:0]    clint_rdata_i,
    input csr_pkg::csr_trap_view_t trap_i,
    input logic [`CSR_XLEN-1:0]    mcountinhibit_i
);

    int                      fail_count = 0;
    csr_pkg::csr_trap_view_t shadow;
    logic                    ex_fwd;
    logic                    clint_fwd;
    logic                    cycle_quiet;  // ex reads mcycle, nobody writes

    // ex first, then clint, else hold
    function automatic logic [`CSR_XLEN-1:0] merged(input logic [`CSR_XLEN-1:0] cur,
                                                    input logic [`CSR_ADDR_W-1:0] addr,
                                                    input csr_pkg::csr_wr_t ex,
                                                    input csr_pkg::csr_wr_t cl);
        if (ex.we && ex.addr == addr) return ex.data;
        if (cl.we && cl.addr == addr) return cl.data;
        return cur;
    endfunction

    function automatic logic known(input logic [`CSR_ADDR_W-1:0] a);
        case (a)
            `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE, `CSR_MSTATUS, `CSR_MIE, `CSR_MSCRATCH,
            `CSR_MTVAL, `CSR_MISA, `CSR_MCOUNTINHIBIT, `CSR_MCYCLE, `CSR_MCYCLEH,
            `CSR_MINSTRET, `CSR_MINSTRETH: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic count_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    always_ff @(posedge clk) begin
        if (rst_i) begin
            shadow <= '0;
        end else begin
            shadow.mtvec   <= merged(shadow.mtvec, `CSR_MTVEC, ex_wr_i, clint_wr_i);
            shadow.mepc    <= merged(shadow.mepc, `CSR_MEPC, ex_wr_i, clint_wr_i);
            shadow.mstatus <= merged(shadow.mstatus, `CSR_MSTATUS, ex_wr_i, clint_wr_i);
            shadow.mie     <= merged(shadow.mie, `CSR_MIE, ex_wr_i, clint_wr_i);
        end
    end

    assign ex_fwd      = ex_wr_i.we && (ex_wr_i.addr == ex_raddr_i);
    assign clint_fwd   = clint_wr_i.we && (clint_wr_i.addr == clint_raddr_i);
    assign cycle_quiet = (ex_raddr_i == `CSR_MCYCLE) && !ex_wr_i.we && !clint_wr_i.we;

    a_trap_view: assert property (@(posedge clk) disable iff (rst_i) trap_i == shadow)
        else count_failure("trap view differs from the write history");
    a_ex_fwd: assert property (@(posedge clk) disable iff (rst_i)
        ex_fwd |-> ex_rdata_i == ex_wr_i.data) else count_failure("ex write not forwarded");
    a_clint_fwd: assert property (@(posedge clk) disable iff (rst_i)
        clint_fwd |-> clint_rdata_i == clint_wr_i.data)
        else count_failure("clint write not forwarded");
    a_misa: assert property (@(posedge clk) disable iff (rst_i)
        !ex_fwd && ex_raddr_i == `CSR_MISA |-> ex_rdata_i == `CSR_MISA_VALUE)
        else count_failure("misa read is not the fixed value");
    a_unknown: assert property (@(posedge clk) disable iff (rst_i)
        !ex_fwd && !known(ex_raddr_i) |-> ex_rdata_i == '0)
        else count_failure("unknown csr read is not zero");
    // one step per cycle unless inhibited
    a_mcycle: assert property (@(posedge clk) disable iff (rst_i)
        cycle_quiet |=> !cycle_quiet || ex_rdata_i - $past(ex_rdata_i) ==
            ($past(mcountinhibit_i[`CSR_INHIBIT_CY]) ? 32'd0 : 32'd1))
        else count_failure("mcycle did not advance as expected");

endmodule

//--- csr_file_tb.sv
/*
 Testbench for csr_file. Drives both ports on the falling clock edge with
 LCG data, compares read data per test and prints a closing summary.
 The concurrent checks of csr_file_asserts are bound into the DUT here.
*/
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_file_tb;

    logic                    clk;
    logic                    rst;
    csr_pkg::csr_wr_t        ex_wr;
    csr_pkg::csr_wr_t        clint_wr;
    logic [`CSR_ADDR_W-1:0]  ex_raddr;
    logic [`CSR_ADDR_W-1:0]  clint_raddr;
    logic                    inst_valid;
    logic [`CSR_XLEN-1:0]    ex_rdata;
    logic [`CSR_XLEN-1:0]    clint_rdata;
    csr_pkg::csr_trap_view_t trap;

    logic [31:0] lcg_state = 32'hb9cc1928;
    int          checks = 0;
    int          errs = 0;
    int          total_checks = 0;
    int          total_errs = 0;

    // test order, mcountinhibit last
    logic [`CSR_ADDR_W-1:0] trap_addr [8] = '{`CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE,
        `CSR_MSTATUS, `CSR_MIE, `CSR_MSCRATCH, `CSR_MTVAL, `CSR_MCOUNTINHIBIT};
    logic [`CSR_ADDR_W-1:0] unknown_addr [4] = '{12'h344, 12'hf14, 12'h7c0, 12'hc00};
    logic [`CSR_XLEN-1:0]   stored [8];

    csr_file u_csr_file (
        .clk(clk), .rst_i(rst), .ex_wr_i(ex_wr), .clint_wr_i(clint_wr),
        .ex_raddr_i(ex_raddr), .clint_raddr_i(clint_raddr), .inst_valid_i(inst_valid),
        .ex_rdata_o(ex_rdata), .clint_rdata_o(clint_rdata), .trap_o(trap)
    );

    bind csr_file csr_file_asserts u_csr_file_asserts (
        .clk(clk), .rst_i(rst_i), .ex_wr_i(ex_wr_i), .clint_wr_i(clint_wr_i),
        .ex_raddr_i(ex_raddr_i), .clint_raddr_i(clint_raddr_i),
        .ex_rdata_i(ex_rdata_o), .clint_rdata_i(clint_rdata_o),
        .trap_i(trap_o), .mcountinhibit_i(mcountinhibit)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic close_test(input string name);
        $display("test %-9s %0d checks, %0d mismatches", name, checks, errs);
        total_checks += checks;
        total_errs   += errs;
        checks = 0;
        errs   = 0;
    endtask

    // falling edge, writes and strobe drop back to idle
    task automatic next_edge();
        @(negedge clk);
        ex_wr      = '0;
        clint_wr   = '0;
        inst_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        int          n;
        rst         = 1'b1;
        ex_wr       = '0;
        clint_wr    = '0;
        ex_raddr    = '0;
        clint_raddr = '0;
        inst_valid  = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 8; i++) begin
            stored[i] = next_rand();
            next_edge();
            ex_wr = {1'b1, trap_addr[i], stored[i]};
            next_edge();
            ex_raddr    = trap_addr[i];
            clint_raddr = trap_addr[i];
            #2;
            compare_value("trap_rw ex", stored[i], ex_rdata);
            compare_value("trap_rw clint", stored[i], clint_rdata);
        end
        close_test("trap_rw");

        a = next_rand();
        b = next_rand();
        next_edge();
        ex_wr       = {1'b1, `CSR_MSCRATCH, a};
        clint_wr    = {1'b1, `CSR_MSCRATCH, b};
        ex_raddr    = `CSR_MSCRATCH;
        clint_raddr = `CSR_MSCRATCH;
        #2;
        compare_value("fwd ex", a, ex_rdata);
        compare_value("fwd clint", b, clint_rdata);
        next_edge();
        #2;
        compare_value("prio ex", a, ex_rdata);
        compare_value("prio clint", a, clint_rdata);
        next_edge();
        ex_wr       = {1'b1, `CSR_MTVAL, b};  // other port, no forwarding
        clint_raddr = `CSR_MTVAL;
        #2;
        compare_value("no fwd clint", stored[6], clint_rdata);
        close_test("priority");

        next_edge();
        ex_wr    = {1'b1, `CSR_MISA, next_rand()};
        ex_raddr = `CSR_MEPC;
        next_edge();
        ex_raddr    = `CSR_MISA;
        clint_raddr = `CSR_MISA;
        #2;
        compare_value("misa ex", `CSR_MISA_VALUE, ex_rdata);
        compare_value("misa clint", `CSR_MISA_VALUE, clint_rdata);
        for (int i = 0; i < 4; i++) begin
            next_edge();
            ex_raddr    = unknown_addr[i];
            clint_raddr = unknown_addr[i];
            #2;
            compare_value("unknown ex", 32'd0, ex_rdata);
            compare_value("unknown clint", 32'd0, clint_rdata);
        end
        close_test("misa");

        next_edge();
        ex_wr = {1'b1, `CSR_MCOUNTINHIBIT, 32'd0};
        next_edge();
        ex_raddr = `CSR_MCYCLE;
        #2;
        a = ex_rdata;
        n = 0;
        while (ex_rdata != a + 32'd20 && n < 100) begin
            next_edge();
            #2;
            n++;
        end
        if (n == 100) begin
            $display("mcycle read never reached the start value plus 20");
            errs++;
        end else begin
            compare_value("mcycle cycles", 32'd20, n);
        end
        next_edge();
        ex_wr = {1'b1, `CSR_MCOUNTINHIBIT, 32'd1 << `CSR_INHIBIT_CY};
        next_edge();
        #2;
        a = ex_rdata;
        repeat (10) next_edge();
        #2;
        compare_value("mcycle held", a, ex_rdata);
        close_test("mcycle");

        next_edge();
        ex_wr = {1'b1, `CSR_MCOUNTINHIBIT, 32'd0};
        next_edge();
        ex_raddr = `CSR_MINSTRET;
        #2;
        a = ex_rdata;
        n = next_rand() % 16 + 1;
        for (int i = 0; i < n; i++) begin
            next_edge();
            inst_valid = 1'b1;
            next_edge();
        end
        #2;
        compare_value("minstret count", a + n, ex_rdata);
        b = next_rand();
        next_edge();
        ex_wr = {1'b1, `CSR_MINSTRET, 32'hffff_ffff};
        next_edge();
        ex_wr = {1'b1, `CSR_MINSTRETH, b};
        next_edge();
        inst_valid  = 1'b1;
        ex_raddr    = `CSR_MINSTRET;
        clint_raddr = `CSR_MINSTRETH;
        next_edge();
        #2;
        compare_value("carry lo", 32'd0, ex_rdata);
        compare_value("carry hi", b + 32'd1, clint_rdata);
        b = next_rand();
        next_edge();
        ex_wr = {1'b1, `CSR_MINSTRET, 32'hffff_ffff};
        next_edge();
        clint_wr   = {1'b1, `CSR_MINSTRETH, b};  // carry lands on the written half
        inst_valid = 1'b1;
        next_edge();
        #2;
        compare_value("hi write lo", 32'd0, ex_rdata);
        compare_value("hi write hi", b + 32'd1, clint_rdata);
        close_test("minstret");

        $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
                 total_checks, total_errs, u_csr_file.u_csr_file_asserts.fail_count);
        if (total_errs == 0 && u_csr_file.u_csr_file_asserts.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- csr_pkg.sv
/*
 Shared packed types of the CSR file: write requests, register selects,
 merged write enables and the register views handed to read ports and clint.
*/
`include "csr_settings.svh"

package csr_pkg;

    // one bit per writable register
    typedef struct packed {
        logic mtvec;
        logic mepc;
        logic mcause;
        logic mstatus;
        logic mie;
        logic mscratch;
        logic mtval;
        logic mcountinhibit;
        logic mcycle;
        logic mcycleh;
        logic minstret;
        logic minstreth;
    } csr_en_t;

    // decoded address, misa is read only so it sits beside the writable set
    typedef struct packed {
        logic    misa;
        csr_en_t regs;
    } csr_sel_t;

    typedef struct packed {
        logic                   we;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   data;
    } csr_wr_t;

    // registers the clint watches
    typedef struct packed {
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] mstatus;
        logic [`CSR_XLEN-1:0] mie;
    } csr_trap_view_t;

    typedef struct packed {
        csr_trap_view_t         trap;
        logic [`CSR_XLEN-1:0]   mcause;
        logic [`CSR_XLEN-1:0]   mscratch;
        logic [`CSR_XLEN-1:0]   mtval;
        logic [`CSR_XLEN-1:0]   mcountinhibit;
        logic [2*`CSR_XLEN-1:0] mcycle;
        logic [2*`CSR_XLEN-1:0] minstret;
    } csr_view_t;

    // merged writes, use_ex picks the ex data word for that register
    typedef struct packed {
        csr_en_t              en;
        csr_en_t              use_ex;
        logic [`CSR_XLEN-1:0] ex_data;
        logic [`CSR_XLEN-1:0] clint_data;
    } csr_wen_t;

endpackage

//--- csr_read_port.sv
/*
 Combinational CSR read for one port.
 Picks the selected register, then forwards this port's own same-cycle write.
*/
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_read_port (
    input  csr_pkg::csr_sel_t      raddr_sel_i,
    input  csr_pkg::csr_view_t     view_i,
    input  csr_pkg::csr_wr_t       wr_i,         // same port's write
    input  logic [`CSR_ADDR_W-1:0] raddr_i,
    output logic [`CSR_XLEN-1:0]   rdata_o
);

    logic [`CSR_XLEN-1:0] reg_val;
    logic                 fwd;

    // select is one-hot or empty, so the order of the ifs does not matter
    always_comb begin
        reg_val = '0;
        if (raddr_sel_i.regs.mtvec)         reg_val = view_i.trap.mtvec;
        if (raddr_sel_i.regs.mepc)          reg_val = view_i.trap.mepc;
        if (raddr_sel_i.regs.mstatus)       reg_val = view_i.trap.mstatus;
        if (raddr_sel_i.regs.mie)           reg_val = view_i.trap.mie;
        if (raddr_sel_i.regs.mcause)        reg_val = view_i.mcause;
        if (raddr_sel_i.regs.mscratch)      reg_val = view_i.mscratch;
        if (raddr_sel_i.regs.mtval)         reg_val = view_i.mtval;
        if (raddr_sel_i.regs.mcountinhibit) reg_val = view_i.mcountinhibit;

        // counter halves
        if (raddr_sel_i.regs.mcycle)    reg_val = view_i.mcycle[`CSR_XLEN-1:0];
        if (raddr_sel_i.regs.mcycleh)   reg_val = view_i.mcycle[2*`CSR_XLEN-1:`CSR_XLEN];
        if (raddr_sel_i.regs.minstret)  reg_val = view_i.minstret[`CSR_XLEN-1:0];
        if (raddr_sel_i.regs.minstreth) reg_val = view_i.minstret[2*`CSR_XLEN-1:`CSR_XLEN];

        if (raddr_sel_i.misa)           reg_val = `CSR_MISA_VALUE;
    end

    assign fwd     = wr_i.we && (wr_i.addr == raddr_i);  // write in flight to this addr
    assign rdata_o = fwd ? wr_i.data : reg_val;

endmodule

//--- csr_settings.svh
/*
 Widths, CSR addresses and misa fields for the machine-mode CSR file.
 Include in any file that needs them; the guard makes repeat includes harmless.
*/
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_XLEN    32  // data width
`define CSR_ADDR_W  12  // kept address bits

// trap setup
`define CSR_MSTATUS        12'h300
`define CSR_MISA           12'h301
`define CSR_MIE            12'h304
`define CSR_MTVEC          12'h305
`define CSR_MCOUNTINHIBIT  12'h320

// trap handling
`define CSR_MSCRATCH       12'h340
`define CSR_MEPC           12'h341
`define CSR_MCAUSE         12'h342
`define CSR_MTVAL          12'h343

// machine counters, low and high halves
`define CSR_MCYCLE         12'hb00
`define CSR_MINSTRET       12'hb02
`define CSR_MCYCLEH        12'hb80
`define CSR_MINSTRETH      12'hb82

// misa fields
`define CSR_MISA_MXL       2'b01  // xlen 32
`define CSR_MISA_EXT_M     1'b1   // bit 12
`define CSR_MISA_EXT_I     1'b1   // bit 8

// mxl, wiri, z..n, m, l..j, i, h..a
`define CSR_MISA_VALUE {`CSR_MISA_MXL, 4'b0000, 13'd0, `CSR_MISA_EXT_M, 3'd0, \
                        `CSR_MISA_EXT_I, 8'd0}

// mcountinhibit bits
`define CSR_INHIBIT_CY  0
`define CSR_INHIBIT_IR  2

`endif

//--- csr_trap_regs.sv
/*
 Trap-handling CSRs plus mcountinhibit, each loaded on its own enable.
 mtvec, mepc, mstatus and mie also leave as one struct for the clint.
*/
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_trap_regs (
    input  logic                    clk,
    input  logic                    rst_i,
    input  csr_pkg::csr_wen_t       wen_i,
    output csr_pkg::csr_trap_view_t trap_o,
    output logic [`CSR_XLEN-1:0]    mcause_o,
    output logic [`CSR_XLEN-1:0]    mscratch_o,
    output logic [`CSR_XLEN-1:0]    mtval_o,
    output logic [`CSR_XLEN-1:0]    mcountinhibit_o
);

    csr_pkg::csr_trap_view_t trap_q;
    logic [`CSR_XLEN-1:0]    mcause_q;
    logic [`CSR_XLEN-1:0]    mscratch_q;
    logic [`CSR_XLEN-1:0]    mtval_q;
    logic [`CSR_XLEN-1:0]    mcountinhibit_q;

    // write data for one register
    function automatic logic [`CSR_XLEN-1:0] pick(input logic from_ex,
                                                   input csr_pkg::csr_wen_t w);
        return from_ex ? w.ex_data : w.clint_data;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            trap_q          <= '0;
            mcause_q        <= '0;
            mscratch_q      <= '0;
            mtval_q         <= '0;
            mcountinhibit_q <= '0;
        end else begin
            if (wen_i.en.mtvec)   trap_q.mtvec   <= pick(wen_i.use_ex.mtvec, wen_i);
            if (wen_i.en.mepc)    trap_q.mepc    <= pick(wen_i.use_ex.mepc, wen_i);
            if (wen_i.en.mstatus) trap_q.mstatus <= pick(wen_i.use_ex.mstatus, wen_i);
            if (wen_i.en.mie)     trap_q.mie     <= pick(wen_i.use_ex.mie, wen_i);

            if (wen_i.en.mcause)   mcause_q   <= pick(wen_i.use_ex.mcause, wen_i);
            if (wen_i.en.mscratch) mscratch_q <= pick(wen_i.use_ex.mscratch, wen_i);
            if (wen_i.en.mtval)    mtval_q    <= pick(wen_i.use_ex.mtval, wen_i);

            // counter gating bits
            if (wen_i.en.mcountinhibit) begin
                mcountinhibit_q <= pick(wen_i.use_ex.mcountinhibit, wen_i);
            end
        end
    end

    assign trap_o          = trap_q;
    assign mcause_o        = mcause_q;
    assign mscratch_o      = mscratch_q;
    assign mtval_o         = mtval_q;
    assign mcountinhibit_o = mcountinhibit_q;

endmodule

//--- csr_write_arb.sv
/*
 Merges the ex and clint write ports into per-register load enables.
 When both ports hit one register in a cycle the ex data is taken.
*/
`timescale 1ns/10ps

module csr_write_arb (
    input  csr_pkg::csr_wr_t  ex_wr_i,
    input  csr_pkg::csr_wr_t  clint_wr_i,
    input  csr_pkg::csr_sel_t ex_sel_i,
    input  csr_pkg::csr_sel_t clint_sel_i,
    output csr_pkg::csr_wen_t wen_o
);

    csr_pkg::csr_en_t ex_hit;
    csr_pkg::csr_en_t clint_hit;

    // misa select bit is dropped here, so misa writes go nowhere
    assign ex_hit    = ex_wr_i.we ? ex_sel_i.regs : '0;
    assign clint_hit = clint_wr_i.we ? clint_sel_i.regs : '0;

    always_comb begin
        wen_o.en         = ex_hit | clint_hit;
        wen_o.use_ex     = ex_hit;       // ex first on a shared target
        wen_o.ex_data    = ex_wr_i.data;
        wen_o.clint_data = clint_wr_i.data;
    end

endmodule

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module csr_file_tb -f verilog.f || exit 1
out=$(./obj_dir/Vcsr_file_tb +verilator+error+limit+1000 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "NO ERRORS" && echo "run.sh: simulation passed" || exit 1

//--- verilog.f
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_write_arb.sv
csr_counter.sv
csr_trap_regs.sv
csr_read_port.sv
csr_file.sv
csr_file_asserts.sv
csr_file_tb.sv
